/* source/sram_pkg.sv */
//------------------------------------------------
// SRAM side definitions: word and address widths,
// memory map and the read and write port bundles
//------------------------------------------------
package sram_pkg;

	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// Memory map shared by the input and weight SRAMs
	localparam int HEADER_ADDR = 0;
	localparam int DATA_BASE   = 1;  // First matrix word

	// Read port, data returns the cycle after the address
	typedef struct packed {
		logic [ADDR_W-1:0] read_address;
	} sram_read_t;

	// Write port toward the result SRAM
	typedef struct packed {
		logic              write_enable;
		logic [ADDR_W-1:0] write_address;
		logic [DATA_W-1:0] write_data;
	} sram_write_t;

endpackage

/* source/attn_pkg.sv */
//------------------------------------------------
// Projection engine types: dimension header,
// sequencer states and pipeline constants
//------------------------------------------------
package attn_pkg;

	// Header word, {rows, cols}
	typedef struct packed {
		logic [15:0] rows;
		logic [15:0] cols;
	} dims_t;

	// One SRAM read word seen either as operand or as header
	typedef union packed {
		logic [sram_pkg::DATA_W-1:0] value;
		dims_t                       dims;
	} sram_word_u;

	typedef logic [7:0] idx_t;  // Loop index

	localparam int NUM_PROJ   = 3;  // Q, K, V
	localparam int PIPE_DEPTH = 2;  // Last issue to result write

	typedef enum logic [2:0] {
		IDLE,
		HEADER,
		CAPTURE,
		RUN,
		DRAIN
	} seq_state_t;

	// Framing of one read pair inside a dot product
	typedef struct packed {
		logic valid;
		logic first;
		logic last;
	} step_t;

endpackage

/* source/qkv_sequencer.sv */
//------------------------------------------------
// Job sequencer: header fetch, dimension capture,
// run and drain, owns dut_ready
//------------------------------------------------
`timescale 1ns/10ps

module qkv_sequencer (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  dut_valid,
	output logic                  dut_ready,
	input  attn_pkg::sram_word_u  input_rdata,
	input  attn_pkg::sram_word_u  weight_rdata,
	input  logic                  issue_done,
	output attn_pkg::dims_t       dims_nm,
	output attn_pkg::dims_t       dims_mp,
	output logic                  start
);

	attn_pkg::seq_state_t state;

	attn_pkg::dims_t dims_nm_q;  // {N, M} for the job
	attn_pkg::dims_t dims_mp_q;  // {M, P} for the job

	logic [1:0] drain_done_cnt;

	// Headers are on the read data during CAPTURE
	assign start = (state == attn_pkg::CAPTURE);

	// Bypass so addr_gen sees the new sizes on the start edge
	assign dims_nm = start ? input_rdata.dims : dims_nm_q;
	assign dims_mp = start ? weight_rdata.dims : dims_mp_q;

	always_ff @(posedge clk) begin
		if (start) begin
			dims_nm_q <= input_rdata.dims;
			dims_mp_q <= weight_rdata.dims;
		end
	end

	//------------------------------------------------
	// Job FSM
	//------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state          <= attn_pkg::IDLE;
			dut_ready      <= 1'b1;
			drain_done_cnt <= '0;
		end else begin
			case (state)
				attn_pkg::IDLE: begin
					if (dut_valid) begin
						state     <= attn_pkg::HEADER;
						dut_ready <= 1'b0;
					end
				end
				attn_pkg::HEADER: begin
					// addr_gen is already on HEADER_ADDR
					state <= attn_pkg::CAPTURE;
				end
				attn_pkg::CAPTURE: begin
					state <= attn_pkg::RUN;
				end
				attn_pkg::RUN: begin
					drain_done_cnt <= '0;
					if (issue_done)
						state <= attn_pkg::DRAIN;
				end
				attn_pkg::DRAIN: begin
					drain_done_cnt <= drain_done_cnt + 1'b1;
					// Last sum reaches the result SRAM on this edge
					if (drain_done_cnt == 2'(attn_pkg::PIPE_DEPTH - 1)) begin
						state     <= attn_pkg::IDLE;
						dut_ready <= 1'b1;
					end
				end
				default: begin
					state     <= attn_pkg::IDLE;
					dut_ready <= 1'b1;
				end
			endcase
		end
	end

endmodule

/* source/addr_gen.sv */
//------------------------------------------------
// Address generator: w, i, j, k loop nest and the
// input and weight read addresses with framing
//------------------------------------------------
`timescale 1ns/10ps

module addr_gen (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  start,
	input  attn_pkg::dims_t       dims_nm,
	input  attn_pkg::dims_t       dims_mp,
	output sram_pkg::sram_read_t  input_rd,
	output sram_pkg::sram_read_t  weight_rd,
	output attn_pkg::step_t       step,
	output logic                  issue_done
);

	logic busy;

	attn_pkg::idx_t w, i, j, k;          // Indices of the pair on the bus
	attn_pkg::idx_t w_n, i_n, j_n, k_n;
	attn_pkg::idx_t n_last, m_last, p_last;

	logic k_wrap, j_wrap, i_wrap;

	logic [sram_pkg::ADDR_W-1:0] m_size, p_size;
	logic [sram_pkg::ADDR_W-1:0] input_addr, weight_addr;

	function automatic logic [sram_pkg::ADDR_W-1:0] widen(attn_pkg::idx_t v);
		return {{(sram_pkg::ADDR_W - $bits(attn_pkg::idx_t)){1'b0}}, v};
	endfunction

	assign n_last = dims_nm.rows[$bits(attn_pkg::idx_t)-1:0] - 1'b1;
	assign m_last = dims_nm.cols[$bits(attn_pkg::idx_t)-1:0] - 1'b1;
	assign p_last = dims_mp.cols[$bits(attn_pkg::idx_t)-1:0] - 1'b1;

	assign m_size = dims_mp.rows[sram_pkg::ADDR_W-1:0];
	assign p_size = dims_mp.cols[sram_pkg::ADDR_W-1:0];

	assign k_wrap = (k == m_last);
	assign j_wrap = (j == p_last);
	assign i_wrap = (i == n_last);

	assign issue_done = busy && k_wrap && j_wrap && i_wrap &&
		(w == attn_pkg::idx_t'(attn_pkg::NUM_PROJ - 1));

	//------------------------------------------------
	// Next indices, k innermost
	//------------------------------------------------
	always_comb begin
		k_n = k_wrap ? '0 : k + 1'b1;
		j_n = k_wrap ? (j_wrap ? '0 : j + 1'b1) : j;
		i_n = (k_wrap && j_wrap) ? (i_wrap ? '0 : i + 1'b1) : i;
		w_n = (k_wrap && j_wrap && i_wrap) ? w + 1'b1 : w;
		if (start) begin
			k_n = '0;
			j_n = '0;
			i_n = '0;
			w_n = '0;
		end
	end

	// I row-major, each W stored column by column
	assign input_addr = sram_pkg::ADDR_W'(sram_pkg::DATA_BASE) +
		widen(i_n) * m_size + widen(k_n);
	assign weight_addr = sram_pkg::ADDR_W'(sram_pkg::DATA_BASE) +
		widen(w_n) * m_size * p_size + widen(j_n) * m_size + widen(k_n);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy      <= 1'b0;
			w         <= '0;
			i         <= '0;
			j         <= '0;
			k         <= '0;
			input_rd  <= '{read_address: sram_pkg::ADDR_W'(sram_pkg::HEADER_ADDR)};
			weight_rd <= '{read_address: sram_pkg::ADDR_W'(sram_pkg::HEADER_ADDR)};
			step      <= '0;
		end else if (start || (busy && !issue_done)) begin
			busy      <= 1'b1;
			w         <= w_n;
			i         <= i_n;
			j         <= j_n;
			k         <= k_n;
			input_rd  <= '{read_address: input_addr};
			weight_rd <= '{read_address: weight_addr};
			step      <= '{valid: 1'b1, first: (k_n == '0), last: (k_n == m_last)};
		end else begin
			// Idle, park on the header word
			busy      <= 1'b0;
			input_rd  <= '{read_address: sram_pkg::ADDR_W'(sram_pkg::HEADER_ADDR)};
			weight_rd <= '{read_address: sram_pkg::ADDR_W'(sram_pkg::HEADER_ADDR)};
			step      <= '0;
		end
	end

endmodule

/* source/dot_product_unit.sv */
//------------------------------------------------
// Dot product unit: multiply and accumulate read
// pairs and write each finished sum in order
//------------------------------------------------
`timescale 1ns/10ps

module dot_product_unit (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  start,
	input  attn_pkg::step_t       step,
	input  attn_pkg::sram_word_u  input_rdata,
	input  attn_pkg::sram_word_u  weight_rdata,
	output sram_pkg::sram_write_t result_wr
);

	attn_pkg::step_t step_d;  // Lines up with the read data

	logic [sram_pkg::DATA_W-1:0] acc;
	logic [sram_pkg::DATA_W-1:0] product;
	logic [sram_pkg::DATA_W-1:0] sum;

	logic [sram_pkg::ADDR_W-1:0] next_addr;
	logic                        wr_en;
	logic [sram_pkg::ADDR_W-1:0] wr_addr;
	logic [sram_pkg::DATA_W-1:0] wr_data;

	// Wraps modulo 2^32
	assign product = input_rdata.value * weight_rdata.value;
	assign sum     = step_d.first ? product : acc + product;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			step_d <= '0;
		else
			step_d <= step;
	end

	always_ff @(posedge clk) begin
		if (step_d.valid)
			acc <= sum;
	end

	//------------------------------------------------
	// Result write, one per finished dot product
	//------------------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wr_en     <= 1'b0;
			next_addr <= '0;
		end else begin
			wr_en <= step_d.valid && step_d.last;
			if (start)
				next_addr <= '0;  // Each job starts at result address 0
			else if (step_d.valid && step_d.last)
				next_addr <= next_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (step_d.valid && step_d.last) begin
			wr_addr <= next_addr;
			wr_data <= sum;
		end
	end

	assign result_wr = '{
		write_enable:  wr_en,
		write_address: wr_addr,
		write_data:    wr_data
	};

endmodule

/* source/attn_top.sv */
//------------------------------------------------
// QKV projection engine top level
//------------------------------------------------
`timescale 1ns/10ps

module attn_top (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  dut_valid,
	output logic                  dut_ready,
	output sram_pkg::sram_read_t  input_rd,
	input  attn_pkg::sram_word_u  input_rdata,
	output sram_pkg::sram_read_t  weight_rd,
	input  attn_pkg::sram_word_u  weight_rdata,
	output sram_pkg::sram_write_t result_wr
);

	attn_pkg::dims_t dims_nm;
	attn_pkg::dims_t dims_mp;
	attn_pkg::step_t step;
	logic            start;
	logic            issue_done;

	qkv_sequencer u_sequencer (
		.clk          (clk),
		.reset_n      (reset_n),
		.dut_valid    (dut_valid),
		.dut_ready    (dut_ready),
		.input_rdata  (input_rdata),
		.weight_rdata (weight_rdata),
		.issue_done   (issue_done),
		.dims_nm      (dims_nm),
		.dims_mp      (dims_mp),
		.start        (start)
	);

	// Also drives the header address between jobs
	addr_gen u_addr_gen (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.dims_nm    (dims_nm),
		.dims_mp    (dims_mp),
		.input_rd   (input_rd),
		.weight_rd  (weight_rd),
		.step       (step),
		.issue_done (issue_done)
	);

	dot_product_unit u_dot_product (
		.clk          (clk),
		.reset_n      (reset_n),
		.start        (start),
		.step         (step),
		.input_rdata  (input_rdata),
		.weight_rdata (weight_rdata),
		.result_wr    (result_wr)
	);

endmodule

/* tests/attn_assert.sv */
//------------------------------------------------
// Protocol assertions for the projection engine
//------------------------------------------------
`timescale 1ns/10ps

module attn_assert (
	input logic                  clk,
	input logic                  reset_n,
	input logic                  dut_valid,
	input logic                  dut_ready,
	input sram_pkg::sram_write_t result_wr,
	input attn_pkg::dims_t       dims_nm,
	input attn_pkg::dims_t       dims_mp
);

	logic [31:0] write_limit;  // 3 * N * P

	assign write_limit = 32'(attn_pkg::NUM_PROJ) * 32'(dims_nm.rows) * 32'(dims_mp.cols);

	no_write_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
		result_wr.write_enable |-> !dut_ready)
		else $error("result write while dut_ready is high");

	// Accepted request drops ready on the next edge
	ready_drops: assert property (@(posedge clk) disable iff (!reset_n)
		(dut_valid && dut_ready) |=> !dut_ready)
		else $error("dut_ready still high one cycle after an accepted dut_valid");

	write_addr_in_range: assert property (@(posedge clk) disable iff (!reset_n)
		result_wr.write_enable |-> (32'(result_wr.write_address) < write_limit))
		else $error("result write address beyond 3*N*P-1");

endmodule

bind attn_top attn_assert u_assert (
	.clk       (clk),
	.reset_n   (reset_n),
	.dut_valid (dut_valid),
	.dut_ready (dut_ready),
	.result_wr (result_wr),
	.dims_nm   (dims_nm),
	.dims_mp   (dims_mp)
);

/* tests/tb_attn_top.sv */
//------------------------------------------------
// Testbench for the QKV projection engine: SRAM
// models, LFSR stimulus and a reference model
//------------------------------------------------
`timescale 1ns/10ps

module tb_attn_top;

	localparam int NUM_JOBS   = 8;
	localparam int MAX_CYCLES = NUM_JOBS * (3 * 8 * 8 * 8 + 20);
	localparam int MEM_WORDS  = 2 ** sram_pkg::ADDR_W;

	logic clk;
	logic reset_n;
	logic dut_valid;
	logic dut_ready;

	sram_pkg::sram_read_t  input_rd;
	sram_pkg::sram_read_t  weight_rd;
	sram_pkg::sram_write_t result_wr;
	attn_pkg::sram_word_u  input_rdata  = '0;
	attn_pkg::sram_word_u  weight_rdata = '0;

	logic [sram_pkg::DATA_W-1:0] input_mem  [MEM_WORDS];
	logic [sram_pkg::DATA_W-1:0] weight_mem [MEM_WORDS];
	logic [sram_pkg::DATA_W-1:0] result_mem [MEM_WORDS];
	logic [sram_pkg::DATA_W-1:0] exp_mem    [MEM_WORDS];  // Model output

	logic [31:0] lfsr_state = 32'd20;
	int cycle_count = 0;
	int exp_count;
	int wr_count;
	int jobs_run;
	int writes_checked;
	int mismatches;
	int other_errors;

	attn_top DUT (
		.clk          (clk),
		.reset_n      (reset_n),
		.dut_valid    (dut_valid),
		.dut_ready    (dut_ready),
		.input_rd     (input_rd),
		.input_rdata  (input_rdata),
		.weight_rd    (weight_rd),
		.weight_rdata (weight_rdata),
		.result_wr    (result_wr)
	);

	always #5 clk = ~clk;

	// SRAM models, read data the cycle after the address
	always @(posedge clk) begin
		input_rdata.value  <= input_mem[input_rd.read_address];
		weight_rdata.value <= weight_mem[weight_rd.read_address];
		if (result_wr.write_enable)
			result_mem[result_wr.write_address] <= result_wr.write_data;
	end

	//------------------------------------------------
	// Random numbers and reporting
	//------------------------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int rand_size();
		return 1 + int'(take_bits(3));  // 1 to 8
	endfunction

	function automatic logic [31:0] pick_operand(input bit big);
		return big ? 32'hFFFF_FFFF - take_bits(4) : take_bits(32);
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
		mismatches++;
	endtask

	task automatic note_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		other_errors++;
	endtask

	//------------------------------------------------
	// Job setup, reference model and one job run
	//------------------------------------------------
	task automatic load_job(input int n, input int m, input int p, input bit big);
		attn_pkg::dims_t hdr;
		logic [31:0] sum;
		hdr = '{rows: 16'(n), cols: 16'(m)};
		input_mem[sram_pkg::HEADER_ADDR] = hdr;
		hdr = '{rows: 16'(m), cols: 16'(p)};
		weight_mem[sram_pkg::HEADER_ADDR] = hdr;
		for (int a = 0; a < n * m; a++)
			input_mem[sram_pkg::DATA_BASE + a] = pick_operand(big);
		for (int a = 0; a < 3 * m * p; a++)
			weight_mem[sram_pkg::DATA_BASE + a] = pick_operand(big);
		// Q, K, V in turn, N x P row-major, sums wrap at 2^32
		for (int w = 0; w < 3; w++)
			for (int i = 0; i < n; i++)
				for (int j = 0; j < p; j++) begin
					sum = '0;
					for (int k = 0; k < m; k++)
						sum += input_mem[sram_pkg::DATA_BASE + i * m + k] *
							weight_mem[sram_pkg::DATA_BASE + w * m * p + j * m + k];
					exp_mem[w * n * p + i * p + j] = sum;
				end
		for (int a = 0; a < MEM_WORDS; a++)
			result_mem[a] <= 32'hC0DE_0000 | 32'(a);
		exp_count = 3 * n * p;
		wr_count  = 0;
	endtask

	task automatic run_job(input int n, input int m, input int p, input bit big,
		input bit poke);
		load_job(n, m, p, big);
		@(negedge clk);
		if (dut_ready !== 1'b1)
			note_failure("dut_ready low before the job was started");
		dut_valid = 1'b1;
		@(negedge clk);
		dut_valid = 1'b0;
		if (dut_ready !== 1'b0)
			note_mismatch("dut_ready", 32'd0, 32'(dut_ready));
		if (poke) begin
			repeat (4) @(negedge clk);
			if (!dut_ready)
				dut_valid = 1'b1;  // Should be ignored
			@(negedge clk);
			dut_valid = 1'b0;
		end
		while (dut_ready !== 1'b1)
			@(negedge clk);
		if (wr_count != exp_count)
			note_mismatch("write count", exp_count, wr_count);
		for (int a = 0; a < exp_count; a++)
			if (result_mem[a] !== exp_mem[a])
				note_mismatch($sformatf("result_mem[%0d]", a), exp_mem[a], result_mem[a]);
		jobs_run++;
	endtask

	// Write monitor, order and value of every result write
	always @(negedge clk) begin
		if (reset_n && result_wr.write_enable) begin
			if (dut_ready)
				note_failure("result write while dut_ready is high");
			if (wr_count >= exp_count) begin
				note_failure("more result writes than 3*N*P");
			end else begin
				if (result_wr.write_address !== sram_pkg::ADDR_W'(wr_count))
					note_mismatch("write_address", wr_count, result_wr.write_address);
				if (result_wr.write_data !== exp_mem[wr_count])
					note_mismatch("write_data", exp_mem[wr_count], result_wr.write_data);
			end
			wr_count++;
			writes_checked++;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the jobs did not finish", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin
		clk            = 1'b0;
		reset_n        = 1'b0;
		dut_valid      = 1'b0;
		exp_count      = 0;
		wr_count       = 0;
		jobs_run       = 0;
		writes_checked = 0;
		mismatches     = 0;
		other_errors   = 0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			input_mem[a]  = 32'h1000_0000 | 32'(a);
			weight_mem[a] = 32'h2000_0000 | 32'(a);
			exp_mem[a]    = '0;
		end
		repeat (5) @(negedge clk);
		reset_n = 1'b1;
		repeat (3) @(negedge clk);
		if (dut_ready !== 1'b1)
			note_mismatch("dut_ready", 32'd1, 32'(dut_ready));
		if (result_wr.write_enable !== 1'b0)
			note_mismatch("write_enable", 32'd0, 32'(result_wr.write_enable));

		run_job(1, 1, 1, 1'b0, 1'b0);
		run_job(1, rand_size(), rand_size(), 1'b0, 1'b0);
		run_job(rand_size(), 1, rand_size(), 1'b0, 1'b0);
		run_job(rand_size(), rand_size(), 1, 1'b0, 1'b0);
		run_job(rand_size(), rand_size(), rand_size(), 1'b1, 1'b0);  // Wraparound
		run_job(8, 8, 8, 1'b0, 1'b1);
		run_job(rand_size(), rand_size(), rand_size(), 1'b0, 1'b1);
		run_job(rand_size(), rand_size(), rand_size(), 1'b0, 1'b0);

		$display("Jobs: %0d, writes checked: %0d, mismatches: %0d, other errors: %0d",
			jobs_run, writes_checked, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* sources.f */
source/sram_pkg.sv
source/attn_pkg.sv
source/qkv_sequencer.sv
source/addr_gen.sv
source/dot_product_unit.sv
source/attn_top.sv
tests/attn_assert.sv
tests/tb_attn_top.sv

/* Makefile */
# Verilator build and run for the QKV projection engine testbench

VERILATOR ?= verilator
TOP       ?= tb_attn_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^PASS: all tests$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
